// ==== Bender.yml ====
package:
  name: mpf_bridge

export_include_dirs:
  - include

sources:
  - files:
      - hw/mpf_bridge_pkg.sv
      - hw/req_fifo.sv
      - hw/read_splitter.sv
      - hw/tag_heap.sv
      - hw/write_credit_counter.sv
      - hw/write_rsp_merger.sv
      - hw/mpf_bridge.sv
  - target: simulation
    files:
      - verification/mpf_bridge_sva.sv
      - verification/mpf_bridge_tb.sv

// ==== hw/mpf_bridge.sv ====
// Top level of the bridge from accelerator requests to a single-line host channel
`timescale 1ns/100ps

`include "mpf_bridge_config.svh"

module mpf_bridge
    import mpf_bridge_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // ------------------------------------------------------------------
    // Accelerator side
    // ------------------------------------------------------------------
    input  rd_req_t      rd_req,
    input  logic         rd_req_valid,
    input  wr_req_t      wr_req,
    input  logic         wr_req_valid,
    output logic         rd_almost_full,
    output logic         wr_almost_full,
    output rd_rsp_t      rd_rsp,
    output logic         rd_rsp_valid,
    output wr_rsp_t      wr_rsp,
    output logic         wr_rsp_valid,

    // ------------------------------------------------------------------
    // Host side
    // ------------------------------------------------------------------
    output host_rd_req_t host_rd_req,
    output logic         host_rd_valid,
    output wr_req_t      host_wr_req,
    output logic         host_wr_valid,
    input  logic         host_rd_almost_full,
    input  logic         host_wr_almost_full,
    input  host_rd_rsp_t host_rd_rsp,
    input  logic         host_rd_rsp_valid,
    input  wr_rsp_t      host_c0_wr_rsp,
    input  logic         host_c0_wr_rsp_valid,
    input  wr_rsp_t      host_c1_wr_rsp,
    input  logic         host_c1_wr_rsp_valid
);

    rd_req_t     rd_first;
    logic        rd_not_empty;
    logic        rd_deq;
    logic        heap_not_full;
    tag_t        alloc_tag;
    logic        alloc_en;
    heap_entry_t alloc_entry;

    // Read path
    req_fifo
    #(
        .DEPTH     (`MPF_RD_FIFO_DEPTH),
        .THRESH    (`MPF_ALM_FULL_THRESH),
        .payload_t (rd_req_t)
    )
    i_rd_fifo
    (
        .clk         (clk),
        .reset       (reset),
        .enq_data    (rd_req),
        .enq_en      (rd_req_valid),
        .first       (rd_first),
        .not_empty   (rd_not_empty),
        .deq_en      (rd_deq),
        .almost_full (rd_almost_full)
    );

    read_splitter i_read_splitter
    (
        .clk              (clk),
        .reset            (reset),
        .req              (rd_first),
        .req_valid        (rd_not_empty),
        .deq              (rd_deq),
        .heap_not_full    (heap_not_full),
        .alloc_tag        (alloc_tag),
        .alloc_en         (alloc_en),
        .alloc_entry      (alloc_entry),
        .host_almost_full (host_rd_almost_full),
        .host_req         (host_rd_req),
        .host_valid       (host_rd_valid)
    );

    tag_heap i_tag_heap
    (
        .clk          (clk),
        .reset        (reset),
        .alloc_en     (alloc_en),
        .alloc_entry  (alloc_entry),
        .alloc_tag    (alloc_tag),
        .not_full     (heap_not_full),
        .rsp          (host_rd_rsp),
        .rsp_valid    (host_rd_rsp_valid),
        .rd_rsp       (rd_rsp),
        .rd_rsp_valid (rd_rsp_valid)
    );

    // Writes are already single line
    assign host_wr_req   = wr_req;
    assign host_wr_valid = wr_req_valid;

    write_credit_counter i_write_credit_counter
    (
        .clk              (clk),
        .reset            (reset),
        .issue            (host_wr_valid),
        .retire           (wr_rsp_valid),
        .host_almost_full (host_wr_almost_full),
        .almost_full      (wr_almost_full)
    );

    write_rsp_merger i_write_rsp_merger
    (
        .clk       (clk),
        .reset     (reset),
        .c0_rsp    (host_c0_wr_rsp),
        .c0_valid  (host_c0_wr_rsp_valid),
        .c1_rsp    (host_c1_wr_rsp),
        .c1_valid  (host_c1_wr_rsp_valid),
        .rsp       (wr_rsp),
        .rsp_valid (wr_rsp_valid)
    );

endmodule

// ==== hw/mpf_bridge_pkg.sv ====
// Package with field types and channel structs of the memory bridge
`include "mpf_bridge_config.svh"

package mpf_bridge_pkg;

    // ------------------------------------------------------------------
    // Basic fields
    // ------------------------------------------------------------------
    typedef logic [`MPF_ADDR_W-1:0]   addr_t;
    typedef logic [`MPF_DATA_W-1:0]   data_t;
    typedef logic [`MPF_MDATA_W-1:0]  mdata_t;
    typedef logic [`MPF_CL_LEN_W-1:0] cl_num_t;

    // Heap index, also used as host read metadata
    typedef logic [$clog2(`MPF_MAX_READS)-1:0] tag_t;

    // ------------------------------------------------------------------
    // Accelerator channels
    // ------------------------------------------------------------------
    typedef struct packed {
        addr_t   addr;
        mdata_t  mdata;
        cl_num_t cl_len;
    } rd_req_t;

    typedef struct packed {
        mdata_t  mdata;
        cl_num_t cl_num;
        data_t   data;
    } rd_rsp_t;

    typedef struct packed {
        addr_t  addr;
        mdata_t mdata;
        data_t  data;
    } wr_req_t;

    typedef struct packed {
        mdata_t mdata;
    } wr_rsp_t;

    // ------------------------------------------------------------------
    // Host channels, single line only
    // ------------------------------------------------------------------
    typedef struct packed {
        addr_t addr;
        tag_t  tag;
    } host_rd_req_t;

    typedef struct packed {
        tag_t  tag;
        data_t data;
    } host_rd_rsp_t;

    // What the heap keeps for each host read
    typedef struct packed {
        mdata_t  mdata;
        cl_num_t cl_num;
    } heap_entry_t;

endpackage

// ==== hw/read_splitter.sv ====
// FSM that turns each multi-line read into single-line host reads
`timescale 1ns/100ps

module read_splitter
    import mpf_bridge_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // Head of the read request queue
    input  rd_req_t      req,
    input  logic         req_valid,
    output logic         deq,

    // Heap allocation
    input  logic         heap_not_full,
    input  tag_t         alloc_tag,
    output logic         alloc_en,
    output heap_entry_t  alloc_entry,

    // Host read channel
    input  logic         host_almost_full,
    output host_rd_req_t host_req,
    output logic         host_valid
);

    typedef enum logic {
        IDLE,
        BURST
    } state_t;

    state_t  state;
    cl_num_t beat;
    cl_num_t cur_beat;
    logic    last_beat;

    // A new request always starts at line zero
    assign cur_beat  = (state == IDLE) ? '0 : beat;
    assign last_beat = (cur_beat == req.cl_len);

    // One beat per cycle while every resource is available
    assign host_valid = req_valid && heap_not_full && !host_almost_full;

    // The tag replaces the metadata on the host side
    assign host_req.addr = req.addr | addr_t'(cur_beat);
    assign host_req.tag  = alloc_tag;

    assign alloc_en           = host_valid;
    assign alloc_entry.mdata  = req.mdata;
    assign alloc_entry.cl_num = cur_beat;

    assign deq = host_valid && last_beat;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            beat  <= '0;
        end
        else if (host_valid)
        begin
            if (last_beat)
            begin
                state <= IDLE;
            end
            else
            begin
                // More lines of the same request follow
                state <= BURST;
                beat  <= cur_beat + cl_num_t'(1);
            end
        end
    end

endmodule

// ==== hw/req_fifo.sv ====
// Register-array FIFO with a type parameter for its payload and almost-full
`timescale 1ns/100ps

module req_fifo
#(
    parameter int DEPTH = 8,
    parameter int THRESH = 2,
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     reset,

    input  payload_t enq_data,
    input  logic     enq_en,

    output payload_t first,
    output logic     not_empty,
    input  logic     deq_en,

    output logic     almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_deq;

    // Pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + PTR_W'(1);
    endfunction

    assign do_deq = deq_en && not_empty;

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_deq)
                rd_ptr <= next_ptr(rd_ptr);

            // Fill level moves only when one side is active alone
            case ({enq_en, do_deq})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    assign first       = mem[rd_ptr];
    assign not_empty   = (count != '0);
    assign almost_full = (count >= CNT_W'(DEPTH - THRESH));

endmodule

// ==== hw/tag_heap.sv ====
// Tag free list and entry store that restore metadata of host read responses
`timescale 1ns/100ps

`include "mpf_bridge_config.svh"

module tag_heap
    import mpf_bridge_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // Allocation by the splitter
    input  logic         alloc_en,
    input  heap_entry_t  alloc_entry,
    output tag_t         alloc_tag,
    output logic         not_full,

    // Host read response in, accelerator response out
    input  host_rd_rsp_t rsp,
    input  logic         rsp_valid,
    output rd_rsp_t      rd_rsp,
    output logic         rd_rsp_valid
);

    localparam int CNT_W = $clog2(`MPF_MAX_READS + 1);

    // ------------------------------------------------------------------
    // Free list, a stack of unused tags
    // ------------------------------------------------------------------
    tag_t             free_stack [`MPF_MAX_READS];
    logic [CNT_W-1:0] free_cnt;
    tag_t             top_idx;

    heap_entry_t entries [`MPF_MAX_READS];

    assign top_idx   = tag_t'(free_cnt - CNT_W'(1));
    assign alloc_tag = free_stack[top_idx];
    assign not_full  = (free_cnt >= CNT_W'(`MPF_ALM_FULL_THRESH + 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `MPF_MAX_READS; i++)
                free_stack[i] <= tag_t'(i);
            free_cnt <= CNT_W'(`MPF_MAX_READS);
        end
        else
        begin
            case ({alloc_en, rsp_valid})
                2'b11:
                begin
                    // Pop and push together, freed tag takes the top slot
                    free_stack[top_idx] <= rsp.tag;
                end
                2'b10:
                begin
                    free_cnt <= free_cnt - CNT_W'(1);
                end
                2'b01:
                begin
                    free_stack[tag_t'(free_cnt)] <= rsp.tag;
                    free_cnt <= free_cnt + CNT_W'(1);
                end
                default:
                begin
                    free_cnt <= free_cnt;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Entry store and registered response
    // ------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (alloc_en)
        begin
            entries[alloc_tag] <= alloc_entry;
        end

        rd_rsp.mdata  <= entries[rsp.tag].mdata;
        rd_rsp.cl_num <= entries[rsp.tag].cl_num;
        rd_rsp.data   <= rsp.data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            rd_rsp_valid <= 1'b0;
        else
            rd_rsp_valid <= rsp_valid;
    end

endmodule

// ==== hw/write_credit_counter.sv ====
// Counter of outstanding writes that drives write almost-full
`timescale 1ns/100ps

`include "mpf_bridge_config.svh"

module write_credit_counter
(
    input  logic clk,
    input  logic reset,

    input  logic issue,
    input  logic retire,

    input  logic host_almost_full,
    output logic almost_full
);

    localparam int CNT_W = $clog2(`MPF_MAX_WRITES + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (issue && !retire)
        begin
            // New write, no response this cycle
            count <= count + CNT_W'(1);
        end
        else if (!issue && retire)
        begin
            count <= count - CNT_W'(1);
        end
    end

    // Stop early enough that the response queue never overflows
    assign almost_full = host_almost_full ||
                         (count >= CNT_W'(`MPF_MAX_WRITES - `MPF_ALM_FULL_THRESH));

endmodule

// ==== hw/write_rsp_merger.sv ====
// Queue for channel-0 write responses merged onto one write response channel
`timescale 1ns/100ps

`include "mpf_bridge_config.svh"

module write_rsp_merger
    import mpf_bridge_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    input  wr_rsp_t c0_rsp,
    input  logic    c0_valid,
    input  wr_rsp_t c1_rsp,
    input  logic    c1_valid,

    output wr_rsp_t rsp,
    output logic    rsp_valid
);

    wr_rsp_t q_first;
    logic    q_not_empty;
    logic    q_deq;

    // Sized for every write the credit counter lets through
    req_fifo
    #(
        .DEPTH     (`MPF_MAX_WRITES),
        .THRESH    (`MPF_ALM_FULL_THRESH),
        .payload_t (wr_rsp_t)
    )
    i_c0_queue
    (
        .clk         (clk),
        .reset       (reset),
        .enq_data    (c0_rsp),
        .enq_en      (c0_valid),
        .first       (q_first),
        .not_empty   (q_not_empty),
        .deq_en      (q_deq),
        .almost_full ()
    );

    // Channel 1 wins, queued channel-0 responses fill the gaps
    assign q_deq     = q_not_empty && !c1_valid;
    assign rsp       = c1_valid ? c1_rsp : q_first;
    assign rsp_valid = c1_valid || q_not_empty;

endmodule

// ==== include/mpf_bridge_config.svh ====
// Widths, depths and flow-control thresholds of the memory bridge
`ifndef MPF_BRIDGE_CONFIG_SVH
`define MPF_BRIDGE_CONFIG_SVH

// ----------------------------------------------------------------------
// Field widths
// ----------------------------------------------------------------------

// Cache-line address
`define MPF_ADDR_W 32

// Line data, shrunk from a full cache line
`define MPF_DATA_W 64

// Accelerator metadata carried with each request
`define MPF_MDATA_W 12

// Line count minus one, so one to four lines
`define MPF_CL_LEN_W 2

// ----------------------------------------------------------------------
// Depths and thresholds
// ----------------------------------------------------------------------

// Host reads in flight, one heap entry each
`define MPF_MAX_READS 16

// Capacity of the channel-0 write response queue
`define MPF_MAX_WRITES 32

// Items a sender may still push after almost-full rises
`define MPF_ALM_FULL_THRESH 4

// Read request queue, threshold plus two
`define MPF_RD_FIFO_DEPTH 6

`endif

// ==== mpf_bridge.f ====
+incdir+include
hw/mpf_bridge_pkg.sv
hw/req_fifo.sv
hw/read_splitter.sv
hw/tag_heap.sv
hw/write_credit_counter.sv
hw/write_rsp_merger.sv
hw/mpf_bridge.sv
verification/mpf_bridge_sva.sv
verification/mpf_bridge_tb.sv

// ==== verification/mpf_bridge_sva.sv ====
// Assertions on host read back-pressure, read response timing and write responses in reset
`timescale 1ns/100ps

module mpf_bridge_sva
(
    input logic clk,
    input logic reset,
    input logic host_rd_almost_full,
    input logic host_rd_valid,
    input logic host_rd_rsp_valid,
    input logic rd_rsp_valid,
    input logic wr_rsp_valid
);

    // ------------------------------------------------------------------
    // Read channel
    // ------------------------------------------------------------------

    // Back-pressure that has lasted more than one cycle stops host reads
    a_no_read_under_backpressure: assert property (
        @(posedge clk) disable iff (reset)
            host_rd_almost_full && $past(host_rd_almost_full) |-> !host_rd_valid
    ) else $error("host read issued while host read almost-full was held");

    // Heap lookup adds exactly one register stage
    a_rd_rsp_follows_host: assert property (
        @(posedge clk) disable iff (reset)
            host_rd_rsp_valid |=> rd_rsp_valid
    ) else $error("read response missing one cycle after host read response");

    // ------------------------------------------------------------------
    // Write channel
    // ------------------------------------------------------------------
    a_no_wr_rsp_in_reset: assert property (
        @(posedge clk) reset && $past(reset) |-> !wr_rsp_valid
    ) else $error("write response valid during reset");

endmodule

// ==== verification/mpf_bridge_tb.sv ====
// Testbench with clock, reset, host model, stimulus, reference function, checks and watchdog
`timescale 1ns/100ps

`include "mpf_bridge_config.svh"

module mpf_bridge_tb
    import mpf_bridge_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_RD     = 30;
    localparam int NUM_WR     = 40;
    localparam int NUM_BP_RD  = 8;
    localparam int BP_CYCLES  = 20;
    localparam int LIMIT_WR   = `MPF_MAX_WRITES - `MPF_ALM_FULL_THRESH;
    localparam int TOTAL_REQ  = NUM_RD + NUM_WR + LIMIT_WR + NUM_BP_RD;
    localparam int TIMEOUT    = TOTAL_REQ * 40 * CLK_PERIOD;

    typedef logic [`MPF_MDATA_W+`MPF_CL_LEN_W-1:0] rsp_key_t;

    logic         clk = 1'b0;
    logic         reset;
    rd_req_t      rd_req;
    logic         rd_req_valid;
    wr_req_t      wr_req;
    logic         wr_req_valid;
    logic         rd_almost_full;
    logic         wr_almost_full;
    rd_rsp_t      rd_rsp;
    logic         rd_rsp_valid;
    wr_rsp_t      wr_rsp;
    logic         wr_rsp_valid;
    host_rd_req_t host_rd_req;
    logic         host_rd_valid;
    wr_req_t      host_wr_req;
    logic         host_wr_valid;
    logic         host_rd_almost_full;
    logic         host_wr_almost_full;
    // Host model outputs start idle
    host_rd_rsp_t host_rd_rsp = '0;
    logic         host_rd_rsp_valid = 1'b0;
    wr_rsp_t      host_c0_wr_rsp = '0;
    logic         host_c0_wr_rsp_valid = 1'b0;
    wr_rsp_t      host_c1_wr_rsp = '0;
    logic         host_c1_wr_rsp_valid = 1'b0;

    logic [31:0]  lfsr_state = 32'hb0e;
    int           mismatch_count = 0;
    int           fail_count = 0;
    int           rd_id = 0;
    int           wr_id = 0;
    logic         hold_wr = 1'b0;

    // Expected traffic and the host's pending work
    rd_rsp_t      rd_expect [rsp_key_t];
    bit           host_expect [addr_t];
    bit           wr_expect [mdata_t];
    host_rd_req_t pend_rd [$];
    mdata_t       pend_wr [$];

    mpf_bridge i_mpf_bridge (.*);

    bind mpf_bridge mpf_bridge_sva i_mpf_bridge_sva
    (
        .clk                 (clk),
        .reset               (reset),
        .host_rd_almost_full (host_rd_almost_full),
        .host_rd_valid       (host_rd_valid),
        .host_rd_rsp_valid   (host_rd_rsp_valid),
        .rd_rsp_valid        (rd_rsp_valid),
        .wr_rsp_valid        (wr_rsp_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------
    // Random numbers, reference model and reporting
    // ------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Line contents as the host memory returns them
    function automatic data_t line_data(input addr_t addr);
        return {addr ^ 32'hc3a5_5a3c, ~addr};
    endfunction

    function automatic rd_rsp_t expected_rsp(input rd_req_t req, input int line);
        rd_rsp_t r;
        r.mdata  = req.mdata;
        r.cl_num = cl_num_t'(line);
        r.data   = line_data(req.addr | addr_t'(line));
        return r;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
        begin
            mismatch_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        fail_count++;
        $display("ERROR: %s", msg);
    endtask

    // ------------------------------------------------------------------
    // Stimulus tasks, called on a falling edge
    // ------------------------------------------------------------------
    task automatic send_read(input int len);
        rd_req_t     req;
        logic [31:0] rnd;
        while (rd_almost_full)
            @(negedge clk);
        rnd        = rand_bits(14);
        req.addr   = {rnd[13:0], rd_id[15:0], 2'b00};
        req.mdata  = mdata_t'(rd_id);
        req.cl_len = cl_num_t'(len);
        rd_id++;
        for (int i = 0; i <= len; i++)
        begin
            host_expect[req.addr | addr_t'(i)] = 1'b1;
            rd_expect[{req.mdata, cl_num_t'(i)}] = expected_rsp(req, i);
        end
        rd_req       = req;
        rd_req_valid = 1'b1;
        @(negedge clk);
        rd_req_valid = 1'b0;
    endtask

    task automatic send_write();
        wr_req_t req;
        while (wr_almost_full)
            @(negedge clk);
        req.addr  = rand_bits(32);
        req.mdata = mdata_t'(wr_id);
        req.data  = {rand_bits(32), rand_bits(32)};
        wr_id++;
        wr_expect[req.mdata] = 1'b1;
        wr_req       = req;
        wr_req_valid = 1'b1;
        @(negedge clk);
        wr_req_valid = 1'b0;
    endtask

    task automatic wait_reads_done();
        while (rd_expect.num() != 0 || host_expect.num() != 0 || pend_rd.size() != 0)
            @(negedge clk);
    endtask

    task automatic wait_writes_done();
        while (wr_expect.num() != 0 || pend_wr.size() != 0)
            @(negedge clk);
    endtask

    // ------------------------------------------------------------------
    // Host model
    // ------------------------------------------------------------------
    always @(posedge clk)
    begin
        if (!reset && host_rd_valid)
        begin
            if (host_rd_almost_full)
                report_failure("host read issued while host read almost-full is high");
            if (!host_expect.exists(host_rd_req.addr))
                report_failure($sformatf("unexpected host read address %h", host_rd_req.addr));
            else
                host_expect.delete(host_rd_req.addr);
            pend_rd.push_back(host_rd_req);
        end
        if (!reset && host_wr_valid)
            pend_wr.push_back(host_wr_req.mdata);
    end

    // Pending reads come back in random order
    always @(negedge clk)
    begin : drive_rd_rsp
        int idx;
        host_rd_rsp_valid = 1'b0;
        if (!reset && pend_rd.size() > 0 && rand_bits(1))
        begin
            idx = int'(rand_bits(8)) % pend_rd.size();
            host_rd_rsp.tag   = pend_rd[idx].tag;
            host_rd_rsp.data  = line_data(pend_rd[idx].addr);
            host_rd_rsp_valid = 1'b1;
            pend_rd.delete(idx);
        end
    end

    // Each write is answered on a randomly chosen channel
    always @(negedge clk)
    begin
        host_c0_wr_rsp_valid = 1'b0;
        host_c1_wr_rsp_valid = 1'b0;
        if (!reset && !hold_wr && pend_wr.size() > 0 && rand_bits(1))
        begin
            if (rand_bits(1))
            begin
                host_c1_wr_rsp.mdata = pend_wr.pop_front();
                host_c1_wr_rsp_valid = 1'b1;
            end
            else
            begin
                host_c0_wr_rsp.mdata = pend_wr.pop_front();
                host_c0_wr_rsp_valid = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Comparison of accelerator-side responses
    // ------------------------------------------------------------------
    always @(posedge clk)
    begin : compare
        rsp_key_t key;
        if (!reset)
        begin
            if (rd_rsp_valid)
            begin
                key = {rd_rsp.mdata, rd_rsp.cl_num};
                if (!rd_expect.exists(key))
                begin
                    report_failure($sformatf("read response for unknown metadata %h line %0d",
                                             rd_rsp.mdata, rd_rsp.cl_num));
                end
                else
                begin
                    check_value("rd_rsp", rd_rsp, rd_expect[key]);
                    rd_expect.delete(key);
                end
            end
            if (wr_rsp_valid)
            begin
                if (!wr_expect.exists(wr_rsp.mdata))
                    report_failure($sformatf("write response %h was never written",
                                             wr_rsp.mdata));
                else
                    wr_expect.delete(wr_rsp.mdata);
            end
            if (host_wr_valid)
                check_value("host_wr_req", host_wr_req, wr_req);
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial
    begin
        int issued;
        reset               = 1'b1;
        rd_req              = '0;
        rd_req_valid        = 1'b0;
        wr_req              = '0;
        wr_req_valid        = 1'b0;
        host_rd_almost_full = 1'b0;
        host_wr_almost_full = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_value("host_rd_valid", host_rd_valid, 0);
        check_value("rd_rsp_valid", rd_rsp_valid, 0);
        check_value("wr_rsp_valid", wr_rsp_valid, 0);
        check_value("rd_almost_full", rd_almost_full, 0);
        check_value("wr_almost_full", wr_almost_full, 0);

        // Single-line reads first, then random lengths
        for (int i = 0; i < NUM_RD; i++)
            send_read((i < 8) ? 0 : int'(rand_bits(2)));
        wait_reads_done();

        for (int i = 0; i < NUM_WR; i++)
            send_write();
        wait_writes_done();

        // Outstanding write limit with host responses withheld
        hold_wr = 1'b1;
        issued  = 0;
        while (!wr_almost_full && issued < LIMIT_WR)
        begin
            send_write();
            issued++;
        end
        if (!wr_almost_full)
            report_failure("write almost-full still low with all write credits outstanding");
        hold_wr = 1'b0;
        wait_writes_done();
        check_value("wr_almost_full", wr_almost_full, 0);

        // Host read back-pressure, released while requests wait
        host_rd_almost_full = 1'b1;
        fork
            begin
                repeat (BP_CYCLES) @(negedge clk);
                host_rd_almost_full = 1'b0;
            end
            for (int i = 0; i < NUM_BP_RD; i++)
                send_read(int'(rand_bits(2)));
        join
        wait_reads_done();
        repeat (2) @(negedge clk);

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // Watchdog sized from the number of requests
    initial
    begin
        #(TIMEOUT);
        $display("ERROR: run did not finish within %0d ns, responses still pending", TIMEOUT);
        $display("Test FAILED");
        $finish;
    end

endmodule
